// ==== mvd_patterns.txt ====
// per MB: mb_x mb_y, 16 vectors {y,x} in z-scan order, 16 expected mvds {y,x} 9 bits each
// picture is 3x2 MBs, mb_x_total 2
00 00 02F8 02F9 02FC 02FD 02FA 02FB 02FE 02FF 0200 0201 0204 0205 0202 0203 0206 0207 005F8 005F9 00003 00004 005FA 005FB 00003 00004 00003 00003 00004 00004 00003 00004 00003 00004
01 00 FD0A FD0B FD0E FD0F FD0C FD0D FD10 FD11 FD12 FD13 FD16 FD17 FD14 FD15 FD18 FD19 3FA0A 3FA0B 00004 00004 3FA0C 3FA0D 00003 00004 00004 00003 00004 00004 00003 00004 00003 00004
02 00 05D8 05D9 05DC 05DD 05DA 05DB 05DE 05DF 05E0 05E1 05E4 05E5 05E2 05E3 05E6 05E7 00BD8 00BD9 00003 00004 00BDA 00BDB 00003 00004 00003 00003 00003 00004 00003 00004 00003 00004
00 01 FF1E FF1F FF22 FF23 FF20 FF21 FF24 FF25 FF26 FF27 FF2A FF2B FF28 FF29 FF2C FF2D 3FA1A 3FA19 00004 00004 3FA19 0000B 00003 00004 00004 00003 00004 00004 00003 00004 00003 00004
01 01 07FE 07FF 0702 0703 0700 0701 0704 0705 0706 0707 070A 070B 0708 0709 070C 070D 015E7 015E8 00003 00004 015E8 00401 00003 00004 00003 00003 00003 00004 00003 00004 00003 00004
02 01 FA3C FA3D FA40 FA41 FA3E FA3F FA42 FA43 FA44 FA45 FA48 FA49 FA46 FA47 FA4A FA4B 3EA57 3EA57 00004 00004 3EA57 3EA58 00003 00004 00004 00003 00004 00004 00003 00004 00003 00004

// ==== filelist.f ====
mvd_geom_pkg.sv
mvd_vec_pkg.sv
mv_ram.sv
mb_seq.sv
nbr_regs.sv
nbr_select.sv
mvd_median.sv
mvd_buf.sv
mvd_cmp_top.sv
mvd_cmp_checker.sv
tb_mvd_cmp.sv

// ==== Makefile ====
TOP = tb_mvd_cmp

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== tb_mvd_cmp.sv ====
/*
 * testbench for the MVD engine
 * runs a 3x2 picture from mvd_patterns.txt and checks every MVD,
 * reading MB n back from the ping-pong buffer while MB n+1 computes
 */
`timescale 1ns/1ps

module tb_mvd_cmp;

import mvd_geom_pkg::*;
import mvd_vec_pkg::*;

localparam int NUM_MB       = 6;
localparam int WORDS_PER_MB = 2 + 2 * BLK_CNT;
localparam int CLK_PERIOD   = 20;
localparam int RST_CYCLES   = 16;
localparam int IDLE_CYCLES  = 50;
localparam int MB_CYCLES    = 200;
// one extra MB allowance covers the final read back
localparam int WATCHDOG_CYCLES = RST_CYCLES + IDLE_CYCLES + (NUM_MB + 1) * MB_CYCLES;

logic                clk;
logic                rst_n;
logic [MB_W_LEN-1:0] mb_x_total;
logic [MB_W_LEN-1:0] mb_x;
logic [MB_W_LEN-1:0] mb_y;
logic                start;
mv_grid_t            fmv;
logic                done;
mv_grid_t            mv_out;
logic                mem_sw;
logic                mvd_rd;
blk_idx_t            mvd_raddr;
mvd_t                mvd_rdata;

logic [17:0] pattern_mem [NUM_MB*WORDS_PER_MB];
int          err_cnt;

mvd_cmp_top #(.LINE_DEPTH(480)) i_dut (
	.clk          (clk),
	.rst_n        (rst_n),
	.mb_x_total_i (mb_x_total),
	.mb_x_i       (mb_x),
	.mb_y_i       (mb_y),
	.start_i      (start),
	.fmv_i        (fmv),
	.done_o       (done),
	.mv_o         (mv_out),
	.mem_sw_i     (mem_sw),
	.mvd_rd_i     (mvd_rd),
	.mvd_raddr_i  (mvd_raddr),
	.mvd_rdata_o  (mvd_rdata)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD/2) clk = ~clk;
end

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("watchdog expired, the DUT stopped making progress");
	$display("STATUS: FAIL");
	$fatal(1, "simulation timed out");
end

// ------------------------------
// helpers
// ------------------------------
task automatic check_value(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
	if (expected !== actual) begin
		err_cnt++;
		$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch");
	end
endtask

function automatic mv_grid_t grid_of(input int mb);
	mv_grid_t g;
	for (int k = 0; k < BLK_CNT; k++)
		g[k] = mv_t'(pattern_mem[mb*WORDS_PER_MB + 2 + k][15:0]);
	return g;
endfunction

function automatic mvd_t expected_mvd(input int mb, input int k);
	return mvd_t'(pattern_mem[mb*WORDS_PER_MB + 2 + BLK_CNT + k]);
endfunction

// start one MB after a random idle gap and wait for done
task automatic run_mb(input int mb);
	mv_grid_t g;
	g = grid_of(mb);
	repeat ($urandom_range(0, 3)) @(posedge clk);
	@(posedge clk);
	mb_x  <= pattern_mem[mb*WORDS_PER_MB][MB_W_LEN-1:0];
	mb_y  <= pattern_mem[mb*WORDS_PER_MB + 1][MB_W_LEN-1:0];
	fmv   <= g;
	start <= 1'b1;
	@(posedge clk);
	start <= 1'b0;
	do
		@(negedge clk);
	while (!done);
	check_value($sformatf("mb%0d mv_o", mb), g, mv_out);
endtask

// read data is valid the cycle after the strobe
task automatic read_mvds(input int mb);
	for (int k = 0; k < BLK_CNT; k++) begin
		@(posedge clk);
		mvd_rd    <= 1'b1;
		mvd_raddr <= blk_idx_t'(k);
		@(posedge clk);
		mvd_rd    <= 1'b0;
		@(negedge clk);
		check_value($sformatf("mb%0d blk%0d mvd", mb, k), expected_mvd(mb, k), mvd_rdata);
	end
endtask

task automatic switch_bank();
	@(posedge clk);
	mem_sw <= 1'b1;
	@(posedge clk);
	mem_sw <= 1'b0;
endtask

// ------------------------------
// main sequence
// ------------------------------
initial begin
	err_cnt    = 0;
	rst_n      = 1'b0;
	mb_x_total = MB_W_LEN'(2);
	mb_x       = '0;
	mb_y       = '0;
	start      = 1'b0;
	fmv        = '0;
	mem_sw     = 1'b0;
	mvd_rd     = 1'b0;
	mvd_raddr  = '0;
	void'($urandom(76582));
	$readmemh("mvd_patterns.txt", pattern_mem);

	repeat (RST_CYCLES) @(posedge clk);
	rst_n <= 1'b1;

	// no start, no done
	repeat (IDLE_CYCLES) begin
		@(negedge clk);
		check_value("idle done_o", 1'b0, done);
	end

	run_mb(0);
	switch_bank();
	for (int mb = 1; mb < NUM_MB; mb++) begin
		fork
			run_mb(mb);
			read_mvds(mb - 1);
		join
		switch_bank();
	end
	read_mvds(NUM_MB - 1);

	if (err_cnt == 0) begin
		$display("STATUS: PASS");
		$finish;
	end else begin
		$display("STATUS: FAIL");
		$fatal(1, "checks failed");
	end
end

endmodule

// ==== mvd_cmp_checker.sv ====
/*
 * control timing assertions for the MVD engine
 * done pulse width, minimum MB latency and no done before the first start
 */
`timescale 1ns/1ps

module mvd_cmp_checker (
	input logic clk,
	input logic rst_n,
	input logic start_i,
	input logic done_o
);

// cycles since the last start, saturating
logic [4:0] since_start;
// set by the first start after reset
logic started;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		since_start <= 5'd31;
	else if (start_i)
		since_start <= 5'd1;
	else if (since_start != 5'd31)
		since_start <= since_start + 5'd1;
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		started <= 1'b0;
	else if (start_i)
		started <= 1'b1;
end

// ------------------------------
// properties
// ------------------------------
done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
	done_o |=> !done_o)
	else $error("done_o held high for more than one cycle");

done_not_early: assert property (@(posedge clk) disable iff (!rst_n)
	done_o |-> since_start > 5'd20)
	else $error("done_o within 20 cycles of start_i");

// after reset done stays low until an MB has been started
done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
	done_o |-> started)
	else $error("done_o high with no start since reset");

endmodule

bind mvd_cmp_top mvd_cmp_checker i_checker (
	.clk     (clk),
	.rst_n   (rst_n),
	.start_i (start_i),
	.done_o  (done_o)
);

// ==== mvd_cmp_top.sv ====
/*
 * H.264 motion vector difference engine, one MB per start pulse
 * connects sequencer, neighbour registers, selector, median,
 * top line memory and the ping-pong output buffer
 */
`timescale 1ns/1ps

module mvd_cmp_top #(
	parameter int LINE_DEPTH = 480
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [mvd_geom_pkg::MB_W_LEN-1:0]   mb_x_total_i,
	input  logic [mvd_geom_pkg::MB_W_LEN-1:0]   mb_x_i,
	input  logic [mvd_geom_pkg::MB_W_LEN-1:0]   mb_y_i,
	input  logic                                start_i,
	input  mvd_vec_pkg::mv_grid_t               fmv_i,
	output logic                                done_o,
	output mvd_vec_pkg::mv_grid_t               mv_o,
	input  logic                                mem_sw_i,
	input  logic                                mvd_rd_i,
	input  mvd_geom_pkg::blk_idx_t              mvd_raddr_i,
	output mvd_vec_pkg::mvd_t                   mvd_rdata_o
);

import mvd_geom_pkg::*;
import mvd_vec_pkg::*;

nbr_ctrl_t ctrl;
blk_idx_t blk;
logic lm_en;
logic lm_we;
logic [$clog2(LINE_DEPTH)-1:0] lm_addr;
logic run_we;
mv_t [3:0] left;
mv_t [3:0] top;
mv_t top_right;
mv_t lm_wdata;
mv_t lm_rdata;
mv_t mv_l;
mv_t mv_u;
mv_t mv_ur;
mv_t mv_c;
mvd_t mvd;

mb_seq #(.LINE_DEPTH(LINE_DEPTH)) u_mb_seq (
	.clk, .rst_n, .start_i, .mb_x_i, .mb_x_total_i, .mb_y_i, .done_o,
	.ctrl_o (ctrl), .blk_o (blk), .lm_en_o (lm_en), .lm_we_o (lm_we),
	.lm_addr_o (lm_addr), .run_we_o (run_we)
);

nbr_regs u_nbr_regs (
	.clk, .rst_n, .start_i, .fmv_i, .ctrl_i (ctrl), .blk_i (blk),
	.lm_rdata_i (lm_rdata), .grid_o (mv_o), .left_o (left), .top_o (top),
	.top_right_o (top_right), .lm_wdata_o (lm_wdata)
);

nbr_select u_nbr_select (
	.grid_i (mv_o), .left_i (left), .top_i (top), .top_right_i (top_right),
	.blk_i (blk), .mv_l_o (mv_l), .mv_u_o (mv_u), .mv_ur_o (mv_ur), .mv_c_o (mv_c)
);

mvd_median u_mvd_median (
	.mv_l_i (mv_l), .mv_u_i (mv_u), .mv_ur_i (mv_ur), .mv_c_i (mv_c), .mvd_o (mvd)
);

// top line memory, one enable split into read and write
mv_ram #(.word_t(mv_t), .DEPTH(LINE_DEPTH)) u_line_mem (
	.clk, .we_i (lm_en & lm_we), .waddr_i (lm_addr), .wdata_i (lm_wdata),
	.re_i (lm_en & ~lm_we), .raddr_i (lm_addr), .rdata_o (lm_rdata)
);

mvd_buf u_mvd_buf (
	.clk, .rst_n, .mem_sw_i, .we_i (run_we), .waddr_i (blk), .wdata_i (mvd),
	.rd_i (mvd_rd_i), .raddr_i (mvd_raddr_i), .rdata_o (mvd_rdata_o)
);

endmodule

// ==== mvd_buf.sv ====
/*
 * ping-pong MVD buffer towards the entropy coder
 * the engine fills one bank while the coder reads the other
 */
`timescale 1ns/1ps

module mvd_buf (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      mem_sw_i,
	input  logic                      we_i,
	input  mvd_geom_pkg::blk_idx_t    waddr_i,
	input  mvd_vec_pkg::mvd_t         wdata_i,
	input  logic                      rd_i,
	input  mvd_geom_pkg::blk_idx_t    raddr_i,
	output mvd_vec_pkg::mvd_t         rdata_o
);

import mvd_geom_pkg::*;
import mvd_vec_pkg::*;

logic bank_r;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		bank_r <= 1'b0;
	else if (mem_sw_i)
		bank_r <= ~bank_r;
end

mv_ram #(
	.word_t (mvd_t),
	.DEPTH  (2 * BLK_CNT)
) u_mvd_ram (
	.clk     (clk),
	.we_i    (we_i),
	.waddr_i ({bank_r, waddr_i}),
	.wdata_i (wdata_i),
	.re_i    (rd_i),
	.raddr_i ({~bank_r, raddr_i}),
	.rdata_o (rdata_o)
);

endmodule

// ==== mvd_median.sv ====
/*
 * median predictor and motion vector difference
 * per component, mvd = current - median(L, U, UR)
 */
`timescale 1ns/1ps

module mvd_median (
	input  mvd_vec_pkg::mv_t  mv_l_i,
	input  mvd_vec_pkg::mv_t  mv_u_i,
	input  mvd_vec_pkg::mv_t  mv_ur_i,
	input  mvd_vec_pkg::mv_t  mv_c_i,
	output mvd_vec_pkg::mvd_t mvd_o
);

import mvd_vec_pkg::*;

// signed median of three, then the widened difference
function automatic logic signed [MV_W:0] med_diff(
	input logic signed [MV_W-1:0] c,
	input logic signed [MV_W-1:0] l,
	input logic signed [MV_W-1:0] u,
	input logic signed [MV_W-1:0] ur
);
	logic signed [MV_W-1:0] lo;
	logic signed [MV_W-1:0] hi;
	logic signed [MV_W-1:0] med;
	lo  = (l < u) ? l : u;
	hi  = (l < u) ? u : l;
	med = (ur < lo) ? lo : ((ur > hi) ? hi : ur);
	return (MV_W+1)'(c) - (MV_W+1)'(med);
endfunction

assign mvd_o.y = med_diff(mv_c_i.y, mv_l_i.y, mv_u_i.y, mv_ur_i.y);
assign mvd_o.x = med_diff(mv_c_i.x, mv_l_i.x, mv_u_i.x, mv_ur_i.x);

endmodule

// ==== nbr_select.sv ====
/*
 * neighbour selection for one 4x4 block
 * picks left, up, up-right and the current vector by block position
 */
`timescale 1ns/1ps

module nbr_select (
	input  mvd_vec_pkg::mv_grid_t       grid_i,
	input  mvd_vec_pkg::mv_t [3:0]      left_i,
	input  mvd_vec_pkg::mv_t [3:0]      top_i,
	input  mvd_vec_pkg::mv_t            top_right_i,
	input  mvd_geom_pkg::blk_idx_t      blk_i,
	output mvd_vec_pkg::mv_t            mv_l_o,
	output mvd_vec_pkg::mv_t            mv_u_o,
	output mvd_vec_pkg::mv_t            mv_ur_o,
	output mvd_vec_pkg::mv_t            mv_c_o
);

import mvd_geom_pkg::*;

blk_xy_t x;
blk_xy_t y;
blk_xy_t x_m1;
blk_xy_t x_p1;
blk_xy_t y_m1;
logic ur_avail;

assign x    = blk_x(blk_i);
assign y    = blk_y(blk_i);
assign x_m1 = x - 2'd1;
assign x_p1 = x + 2'd1;
assign y_m1 = y - 2'd1;

// up-right not coded yet: right MB column below the top row,
// or odd/odd blocks whose up-right sits later in z-scan
assign ur_avail = !((x == 2'd3 && y != 2'd0) || (x[0] && y[0]));

assign mv_c_o = grid_i[blk_i];

always_comb begin
	if (x == 2'd0)
		mv_l_o = left_i[y];
	else
		mv_l_o = grid_i[blk_of(x_m1, y)];
end

always_comb begin
	if (y == 2'd0)
		mv_u_o = top_i[x];
	else
		mv_u_o = grid_i[blk_of(x, y_m1)];
end

always_comb begin
	if (!ur_avail)
		// up-left, always inside the MB here
		mv_ur_o = grid_i[blk_of(x_m1, y_m1)];
	else if (y != 2'd0)
		mv_ur_o = grid_i[blk_of(x_p1, y_m1)];
	else if (x == 2'd3)
		mv_ur_o = top_right_i;
	else
		mv_ur_o = top_i[x_p1];
end

endmodule

// ==== nbr_regs.sv ====
/*
 * neighbour registers
 * holds the latched block grid, the left column of the previous MB and
 * the top row plus top-right word read back from the line memory
 */
`timescale 1ns/1ps

module nbr_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start_i,
	input  mvd_vec_pkg::mv_grid_t       fmv_i,
	input  mvd_vec_pkg::nbr_ctrl_t      ctrl_i,
	input  mvd_geom_pkg::blk_idx_t      blk_i,
	input  mvd_vec_pkg::mv_t            lm_rdata_i,
	output mvd_vec_pkg::mv_grid_t       grid_o,
	output mvd_vec_pkg::mv_t [3:0]      left_o,
	output mvd_vec_pkg::mv_t [3:0]      top_o,
	output mvd_vec_pkg::mv_t            top_right_o,
	output mvd_vec_pkg::mv_t            lm_wdata_o
);

import mvd_geom_pkg::*;
import mvd_vec_pkg::*;

mv_grid_t grid_r;
mv_t [3:0] left_r;
mv_t [3:0] top_r;
mv_t top_right_r;

// a start while busy is dropped
always_ff @(posedge clk) begin
	if (start_i && ctrl_i.idle)
		grid_r <= fmv_i;
end

// ------------------------------
// top neighbours
// ------------------------------
always_ff @(posedge clk) begin
	if (ctrl_i.clr_top) begin
		top_r       <= '0;
		top_right_r <= '0;
	end else if (ctrl_i.load_en) begin
		if (ctrl_i.load_slot == SLOT_TR)
			// right picture edge, up-left block U2 stands in
			top_right_r <= ctrl_i.right_edge ? top_r[2] : lm_rdata_i;
		else
			top_r[ctrl_i.load_slot[1:0]] <= lm_rdata_i;
	end
end

// ------------------------------
// left neighbours
// ------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		left_r <= '0;
	end else if (ctrl_i.shift_left) begin
		for (int y = 0; y < 4; y++)
			left_r[y] <= ctrl_i.clr_left ? mv_t'('0) : grid_r[blk_of(2'd3, 2'(y))];
	end
end

// bottom row goes back to the line memory
assign lm_wdata_o  = grid_r[blk_of(blk_i[1:0], 2'd3)];
assign grid_o      = grid_r;
assign left_o      = left_r;
assign top_o       = top_r;
assign top_right_o = top_right_r;

endmodule

// ==== mb_seq.sv ====
/*
 * macroblock sequencer
 * walks LOAD, RUN and STORE for one MB, drives the line memory port,
 * the block index and the neighbour register control, pulses done at the end
 */
`timescale 1ns/1ps

module mb_seq #(
	parameter int LINE_DEPTH = 480
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start_i,
	input  logic [mvd_geom_pkg::MB_W_LEN-1:0]   mb_x_i,
	input  logic [mvd_geom_pkg::MB_W_LEN-1:0]   mb_x_total_i,
	input  logic [mvd_geom_pkg::MB_W_LEN-1:0]   mb_y_i,
	output logic                                done_o,
	output mvd_vec_pkg::nbr_ctrl_t              ctrl_o,
	output mvd_geom_pkg::blk_idx_t              blk_o,
	output logic                                lm_en_o,
	output logic                                lm_we_o,
	output logic [$clog2(LINE_DEPTH)-1:0]       lm_addr_o,
	output logic                                run_we_o
);

import mvd_geom_pkg::*;

localparam int AW = $clog2(LINE_DEPTH);

seq_state_t state_r;
seq_state_t state_nxt;
logic [3:0] cnt_r;
logic [AW-1:0] base_r;
logic top_row_r;
logic row_end_r;
logic ld_done;
logic run_done;
logic st_done;

// ------------------------------
// state machine
// ------------------------------
assign ld_done  = (state_r == LOAD) && (top_row_r || cnt_r == 4'd5);
assign run_done = (state_r == RUN) && (cnt_r == 4'(BLK_CNT - 1));
assign st_done  = (state_r == STORE) && (cnt_r == 4'd3);

always_comb begin
	state_nxt = state_r;
	case (state_r)
		IDLE:    if (start_i) state_nxt = LOAD;
		LOAD:    if (ld_done) state_nxt = RUN;
		RUN:     if (run_done) state_nxt = STORE;
		STORE:   if (st_done) state_nxt = IDLE;
		default: state_nxt = IDLE;
	endcase
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state_r   <= IDLE;
		cnt_r     <= '0;
		top_row_r <= 1'b0;
		row_end_r <= 1'b0;
		base_r    <= '0;
		done_o    <= 1'b0;
	end else begin
		state_r <= state_nxt;
		done_o  <= st_done;
		if (ld_done || run_done || st_done)
			cnt_r <= '0;
		else if (state_r != IDLE)
			cnt_r <= cnt_r + 4'd1;
		// picture position is sampled once per MB
		if (state_r == IDLE && start_i) begin
			top_row_r <= (mb_y_i == '0);
			row_end_r <= (mb_x_i == mb_x_total_i);
		end
		// four line memory words per MB column
		if (st_done)
			base_r <= row_end_r ? '0 : base_r + AW'(4);
	end
end

// ------------------------------
// memory and neighbour control
// ------------------------------
assign blk_o     = cnt_r;
assign run_we_o  = (state_r == RUN);
assign lm_we_o   = (state_r == STORE);
assign lm_en_o   = (state_r == STORE) || (state_r == LOAD && !top_row_r && cnt_r <= 4'd4);
assign lm_addr_o = base_r + AW'(cnt_r);

// read data lags the address by one cycle, hence slot = cnt - 1
always_comb begin
	ctrl_o            = '0;
	ctrl_o.idle       = (state_r == IDLE);
	ctrl_o.load_en    = (state_r == LOAD) && !top_row_r && (cnt_r != 4'd0);
	ctrl_o.load_slot  = 3'(cnt_r - 4'd1);
	ctrl_o.clr_top    = (state_r == LOAD) && top_row_r;
	ctrl_o.right_edge = row_end_r;
	ctrl_o.shift_left = st_done;
	ctrl_o.clr_left   = row_end_r;
end

endmodule

// ==== mv_ram.sv ====
/*
 * simple dual port ram, one write port and one registered read port
 * word type is a parameter so it serves vectors and differences alike
 */
`timescale 1ns/1ps

module mv_ram #(
	parameter type word_t = logic [15:0],
	parameter int  DEPTH  = 16
) (
	input  logic                     clk,
	input  logic                     we_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  word_t                    wdata_i,
	input  logic                     re_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_i,
	output word_t                    rdata_o
);

word_t mem [DEPTH];

always_ff @(posedge clk) begin
	if (we_i)
		mem[waddr_i] <= wdata_i;
end

// data valid the cycle after re_i
always_ff @(posedge clk) begin
	if (re_i)
		rdata_o <= mem[raddr_i];
end

endmodule

// ==== mvd_vec_pkg.sv ====
/*
 * motion vector types for the MVD engine
 * vectors, differences, the per-MB block grid and neighbour register control
 */
package mvd_vec_pkg;

	localparam int MV_W = 8;

	// load slot of the top-right word, U0..U3 use slots 0..3
	localparam logic [2:0] SLOT_TR = 3'd4;

	typedef struct packed {
		logic signed [MV_W-1:0] y;
		logic signed [MV_W-1:0] x;
	} mv_t;

	// one extra bit so the difference never wraps
	typedef struct packed {
		logic signed [MV_W:0] y;
		logic signed [MV_W:0] x;
	} mvd_t;

	// sixteen 4x4 vectors in z-scan order
	typedef mv_t [mvd_geom_pkg::BLK_CNT-1:0] mv_grid_t;

	typedef struct packed {
		logic       idle;
		logic       load_en;
		logic [2:0] load_slot;
		logic       clr_top;
		logic       right_edge;
		logic       shift_left;
		logic       clr_left;
	} nbr_ctrl_t;

endpackage

// ==== mvd_geom_pkg.sv ====
/*
 * macroblock geometry for the MVD engine
 * coordinate widths, z-scan block indexing and sequencer states
 */
package mvd_geom_pkg;

	// mb column coordinate, enough for 1920 wide pictures
	localparam int MB_W_LEN = 7;
	localparam int BLK_CNT  = 16;
	localparam int BLK_XY_W = 2;

	typedef logic [3:0]          blk_idx_t;
	typedef logic [BLK_XY_W-1:0] blk_xy_t;

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		LOAD  = 2'b01,
		RUN   = 2'b10,
		STORE = 2'b11
	} seq_state_t;

	// z-scan index bits are {y1, x1, y0, x0}
	function automatic blk_xy_t blk_x(input blk_idx_t k);
		return {k[2], k[0]};
	endfunction

	function automatic blk_xy_t blk_y(input blk_idx_t k);
		return {k[3], k[1]};
	endfunction

	function automatic blk_idx_t blk_of(input blk_xy_t x, input blk_xy_t y);
		return {y[1], x[1], y[0], x[0]};
	endfunction

endpackage
